// File: Bender.yml
package:
  name: mips_lite

sources:
  - logic/mips_isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/inst_fetch.sv
  - logic/regfile.sv
  - logic/decode.sv
  - logic/execute.sv
  - logic/cpu_core.sv
  - target: simulation
    files:
      - verif/wb_inst_rom.sv
      - verif/cpu_core_tb.sv

// File: logic/cpu_core.sv
`timescale 1ns/100ps

module cpu_core #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                    clk,
    input  logic                    reset_i,

    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output mips_isa_pkg::word_t     wb_adr_o,
    input  mips_isa_pkg::word_t     wb_dat_i,
    input  logic                    wb_ack_i,

    // retire trace
    output mips_isa_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]              debug_wb_rf_wen_o,
    output mips_isa_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output mips_isa_pkg::word_t     debug_wb_rf_wdata_o
);

// fetch -> decode
logic                    if_valid;
mips_isa_pkg::word_t     if_pc, if_inst;
// decode <-> regfile
mips_isa_pkg::reg_addr_t rf_raddr1, rf_raddr2;
mips_isa_pkg::word_t     rf_rdata1, rf_rdata2;
// decode -> execute
logic                    id_valid, id_we;
mips_isa_pkg::word_t     id_pc, id_opa, id_opb;
pipe_pkg::alu_op_t       id_alu_op;
logic [4:0]              id_shamt;
mips_isa_pkg::reg_addr_t id_waddr;
// execute -> decode bypass
logic                    ex_we;
mips_isa_pkg::reg_addr_t ex_waddr;
mips_isa_pkg::word_t     ex_result;
// writeback
logic                    wb_we;
mips_isa_pkg::reg_addr_t wb_waddr;
mips_isa_pkg::word_t     wb_wdata, wb_pc;

assign debug_wb_pc_o       = wb_pc;
assign debug_wb_rf_wen_o   = {4{wb_we}};   // full word writes only
assign debug_wb_rf_wnum_o  = wb_waddr;
assign debug_wb_rf_wdata_o = wb_wdata;

inst_fetch #(
    .RESET_PC(RESET_PC)
) inst_fetch_instance (
    .clk(clk),
    .reset_i(reset_i),
    .wb_cyc_o(wb_cyc_o),
    .wb_stb_o(wb_stb_o),
    .wb_adr_o(wb_adr_o),
    .wb_dat_i(wb_dat_i),
    .wb_ack_i(wb_ack_i),
    .if_valid_o(if_valid),
    .if_pc_o(if_pc),
    .if_inst_o(if_inst)
);

decode decode_instance (
    .clk(clk),
    .reset_i(reset_i),
    .if_valid_i(if_valid),
    .if_pc_i(if_pc),
    .if_inst_i(if_inst),
    .rf_raddr1_o(rf_raddr1),
    .rf_raddr2_o(rf_raddr2),
    .rf_rdata1_i(rf_rdata1),
    .rf_rdata2_i(rf_rdata2),
    .ex_we_i(ex_we),
    .ex_waddr_i(ex_waddr),
    .ex_result_i(ex_result),
    .id_valid_o(id_valid),
    .id_pc_o(id_pc),
    .id_alu_op_o(id_alu_op),
    .id_opa_o(id_opa),
    .id_opb_o(id_opb),
    .id_shamt_o(id_shamt),
    .id_we_o(id_we),
    .id_waddr_o(id_waddr)
);

regfile regfile_instance (
    .clk(clk),
    .reset_i(reset_i),
    .raddr1_i(rf_raddr1),
    .raddr2_i(rf_raddr2),
    .rdata1_o(rf_rdata1),
    .rdata2_o(rf_rdata2),
    .we_i(wb_we),
    .waddr_i(wb_waddr),
    .wdata_i(wb_wdata)
);

execute execute_instance (
    .clk(clk),
    .reset_i(reset_i),
    .id_valid_i(id_valid),
    .id_pc_i(id_pc),
    .id_alu_op_i(id_alu_op),
    .id_opa_i(id_opa),
    .id_opb_i(id_opb),
    .id_shamt_i(id_shamt),
    .id_we_i(id_we),
    .id_waddr_i(id_waddr),
    .ex_we_o(ex_we),
    .ex_waddr_o(ex_waddr),
    .ex_result_o(ex_result),
    .wb_we_o(wb_we),
    .wb_waddr_o(wb_waddr),
    .wb_wdata_o(wb_wdata),
    .wb_pc_o(wb_pc)
);

endmodule

// File: logic/decode.sv
`timescale 1ns/100ps

module decode (
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic                    if_valid_i,
    input  mips_isa_pkg::word_t     if_pc_i,
    input  mips_isa_pkg::word_t     if_inst_i,

    output mips_isa_pkg::reg_addr_t rf_raddr1_o,
    output mips_isa_pkg::reg_addr_t rf_raddr2_o,
    input  mips_isa_pkg::word_t     rf_rdata1_i,
    input  mips_isa_pkg::word_t     rf_rdata2_i,

    // result of the instruction now in execute
    input  logic                    ex_we_i,
    input  mips_isa_pkg::reg_addr_t ex_waddr_i,
    input  mips_isa_pkg::word_t     ex_result_i,

    output logic                    id_valid_o,
    output mips_isa_pkg::word_t     id_pc_o,
    output pipe_pkg::alu_op_t       id_alu_op_o,
    output mips_isa_pkg::word_t     id_opa_o,
    output mips_isa_pkg::word_t     id_opb_o,
    output logic [4:0]              id_shamt_o,
    output logic                    id_we_o,
    output mips_isa_pkg::reg_addr_t id_waddr_o
);

mips_isa_pkg::opcode_t   opcode;
mips_isa_pkg::funct_t    funct;
mips_isa_pkg::reg_addr_t rs, rt, rd;
logic [4:0]              shamt;
logic [15:0]             imm;
mips_isa_pkg::word_t     src1, src2;
mips_isa_pkg::word_t     opa, opb;
pipe_pkg::alu_op_t       alu_op;
mips_isa_pkg::reg_addr_t waddr;
logic                    we;

assign opcode = if_inst_i[31:26];
assign rs     = if_inst_i[25:21];
assign rt     = if_inst_i[20:16];
assign rd     = if_inst_i[15:11];
assign shamt  = if_inst_i[10:6];
assign funct  = if_inst_i[5:0];
assign imm    = if_inst_i[15:0];

assign rf_raddr1_o = rs;
assign rf_raddr2_o = rt;

// execute wins over the register file
assign src1 = (ex_we_i && ex_waddr_i == rs) ? ex_result_i : rf_rdata1_i;
assign src2 = (ex_we_i && ex_waddr_i == rt) ? ex_result_i : rf_rdata2_i;

always_comb begin
    alu_op = pipe_pkg::ALU_NONE;
    opa    = src1;
    opb    = src2;
    waddr  = rd;
    if (opcode == mips_isa_pkg::OP_SPECIAL) begin
        case (funct)
            mips_isa_pkg::FN_SLL:  alu_op = pipe_pkg::ALU_SLL;
            mips_isa_pkg::FN_SRL:  alu_op = pipe_pkg::ALU_SRL;
            mips_isa_pkg::FN_SRA:  alu_op = pipe_pkg::ALU_SRA;
            mips_isa_pkg::FN_ADDU: alu_op = pipe_pkg::ALU_ADD;
            mips_isa_pkg::FN_SUBU: alu_op = pipe_pkg::ALU_SUB;
            mips_isa_pkg::FN_AND:  alu_op = pipe_pkg::ALU_AND;
            mips_isa_pkg::FN_OR:   alu_op = pipe_pkg::ALU_OR;
            mips_isa_pkg::FN_XOR:  alu_op = pipe_pkg::ALU_XOR;
            mips_isa_pkg::FN_NOR:  alu_op = pipe_pkg::ALU_NOR;
            mips_isa_pkg::FN_SLT:  alu_op = pipe_pkg::ALU_SLT;
            mips_isa_pkg::FN_SLTU: alu_op = pipe_pkg::ALU_SLTU;
            default:               alu_op = pipe_pkg::ALU_NONE;
        endcase
    end else begin
        waddr = rt;
        opb   = {{16{imm[15]}}, imm};   // sign extended unless noted
        case (opcode)
            mips_isa_pkg::OP_ADDIU: alu_op = pipe_pkg::ALU_ADD;
            mips_isa_pkg::OP_SLTI:  alu_op = pipe_pkg::ALU_SLT;
            mips_isa_pkg::OP_ANDI: begin
                alu_op = pipe_pkg::ALU_AND;
                opb    = {16'h0, imm};
            end
            mips_isa_pkg::OP_ORI: begin
                alu_op = pipe_pkg::ALU_OR;
                opb    = {16'h0, imm};
            end
            mips_isa_pkg::OP_XORI: begin
                alu_op = pipe_pkg::ALU_XOR;
                opb    = {16'h0, imm};
            end
            mips_isa_pkg::OP_LUI: begin
                alu_op = pipe_pkg::ALU_OR;  // 0 | imm<<16
                opa    = '0;
                opb    = {imm, 16'h0};
            end
            default: alu_op = pipe_pkg::ALU_NONE;
        endcase
    end
end

assign we = if_valid_i && (alu_op != pipe_pkg::ALU_NONE) && (waddr != '0);

always_ff @(posedge clk) begin
    if (reset_i) begin
        id_valid_o  <= 1'b0;
        id_we_o     <= 1'b0;
        id_alu_op_o <= pipe_pkg::ALU_NONE;
    end else begin
        id_valid_o  <= if_valid_i && (alu_op != pipe_pkg::ALU_NONE);
        id_we_o     <= we;
        id_alu_op_o <= if_valid_i ? alu_op : pipe_pkg::ALU_NONE;
    end
end

always_ff @(posedge clk) begin
    id_pc_o    <= if_pc_i;
    id_opa_o   <= opa;
    id_opb_o   <= opb;
    id_shamt_o <= shamt;
    id_waddr_o <= waddr;
end

endmodule

// File: logic/execute.sv
`timescale 1ns/100ps

module execute (
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic                    id_valid_i,
    input  mips_isa_pkg::word_t     id_pc_i,
    input  pipe_pkg::alu_op_t       id_alu_op_i,
    input  mips_isa_pkg::word_t     id_opa_i,
    input  mips_isa_pkg::word_t     id_opb_i,
    input  logic [4:0]              id_shamt_i,
    input  logic                    id_we_i,
    input  mips_isa_pkg::reg_addr_t id_waddr_i,

    // forwarding path back to decode
    output logic                    ex_we_o,
    output mips_isa_pkg::reg_addr_t ex_waddr_o,
    output mips_isa_pkg::word_t     ex_result_o,

    output logic                    wb_we_o,
    output mips_isa_pkg::reg_addr_t wb_waddr_o,
    output mips_isa_pkg::word_t     wb_wdata_o,
    output mips_isa_pkg::word_t     wb_pc_o
);

always_comb begin
    case (id_alu_op_i)
        pipe_pkg::ALU_ADD:  ex_result_o = id_opa_i + id_opb_i;   // wraps
        pipe_pkg::ALU_SUB:  ex_result_o = id_opa_i - id_opb_i;
        pipe_pkg::ALU_AND:  ex_result_o = id_opa_i & id_opb_i;
        pipe_pkg::ALU_OR:   ex_result_o = id_opa_i | id_opb_i;
        pipe_pkg::ALU_XOR:  ex_result_o = id_opa_i ^ id_opb_i;
        pipe_pkg::ALU_NOR:  ex_result_o = ~(id_opa_i | id_opb_i);
        pipe_pkg::ALU_SLT:  ex_result_o = {31'b0, $signed(id_opa_i) < $signed(id_opb_i)};
        pipe_pkg::ALU_SLTU: ex_result_o = {31'b0, id_opa_i < id_opb_i};
        // shifts act on rt
        pipe_pkg::ALU_SLL:  ex_result_o = id_opb_i << id_shamt_i;
        pipe_pkg::ALU_SRL:  ex_result_o = id_opb_i >> id_shamt_i;
        pipe_pkg::ALU_SRA:  ex_result_o = $signed(id_opb_i) >>> id_shamt_i;
        default:            ex_result_o = '0;
    endcase
end

assign ex_we_o    = id_we_i;
assign ex_waddr_o = id_waddr_i;

always_ff @(posedge clk) begin
    if (reset_i) begin
        wb_we_o <= 1'b0;
    end else begin
        wb_we_o <= id_valid_i && id_we_i;
    end
end

always_ff @(posedge clk) begin
    wb_waddr_o <= id_waddr_i;
    wb_wdata_o <= ex_result_o;
    if (id_valid_i) begin
        wb_pc_o <= id_pc_i; // last retired pc
    end
end

endmodule

// File: logic/inst_fetch.sv
`timescale 1ns/100ps

module inst_fetch #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                clk,
    input  logic                reset_i,

    // wishbone classic, read only
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output mips_isa_pkg::word_t wb_adr_o,
    input  mips_isa_pkg::word_t wb_dat_i,
    input  logic                wb_ack_i,

    output logic                if_valid_o,
    output mips_isa_pkg::word_t if_pc_o,
    output mips_isa_pkg::word_t if_inst_o
);

pipe_pkg::fetch_state_t state_q;
mips_isa_pkg::word_t pc_q;
logic fetch_done;

assign fetch_done = (state_q == pipe_pkg::FETCH_BUS) && wb_ack_i;

// cyc and stb move together, address held until ack
assign wb_cyc_o = (state_q == pipe_pkg::FETCH_BUS);
assign wb_stb_o = (state_q == pipe_pkg::FETCH_BUS);
assign wb_adr_o = pc_q;

always_ff @(posedge clk) begin
    if (reset_i) begin
        state_q    <= pipe_pkg::FETCH_IDLE;
        pc_q       <= RESET_PC;
        if_valid_o <= 1'b0;
    end else begin
        if_valid_o <= fetch_done;   // one cycle per ack
        case (state_q)
            pipe_pkg::FETCH_IDLE: begin
                state_q <= pipe_pkg::FETCH_BUS;
            end
            pipe_pkg::FETCH_BUS: begin
                if (wb_ack_i) begin
                    pc_q <= pc_q + 32'd4; // stb stays up for the next word
                end
            end
            default: begin
                state_q <= pipe_pkg::FETCH_IDLE;
            end
        endcase
    end
end

// fetched word and its address
always_ff @(posedge clk) begin
    if (fetch_done) begin
        if_pc_o   <= pc_q;
        if_inst_o <= wb_dat_i;
    end
end

endmodule

// File: logic/mips_isa_pkg.sv
package mips_isa_pkg;

typedef logic [31:0] word_t;      // data, instruction or address
typedef logic [4:0]  reg_addr_t;
typedef logic [5:0]  opcode_t;
typedef logic [5:0]  funct_t;

// primary opcodes
localparam opcode_t OP_SPECIAL = 6'h00;
localparam opcode_t OP_ADDIU   = 6'h09;
localparam opcode_t OP_SLTI    = 6'h0a;
localparam opcode_t OP_ANDI    = 6'h0c;
localparam opcode_t OP_ORI     = 6'h0d;
localparam opcode_t OP_XORI    = 6'h0e;
localparam opcode_t OP_LUI     = 6'h0f;

// function codes under OP_SPECIAL
localparam funct_t FN_SLL  = 6'h00;
localparam funct_t FN_SRL  = 6'h02;
localparam funct_t FN_SRA  = 6'h03;
localparam funct_t FN_ADDU = 6'h21;
localparam funct_t FN_SUBU = 6'h23;
localparam funct_t FN_AND  = 6'h24;
localparam funct_t FN_OR   = 6'h25;
localparam funct_t FN_XOR  = 6'h26;
localparam funct_t FN_NOR  = 6'h27;
localparam funct_t FN_SLT  = 6'h2a;
localparam funct_t FN_SLTU = 6'h2b;

localparam word_t INST_NOP = 32'h0000_0000; // sll r0, r0, 0

endpackage

// File: logic/pipe_pkg.sv
package pipe_pkg;

// operation handed from decode to execute
typedef enum logic [3:0] {
    ALU_NONE,   // bubble, result unused
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
} alu_op_t;

typedef enum logic {
    FETCH_IDLE,
    FETCH_BUS   // request held on the bus
} fetch_state_t;

endpackage

// File: logic/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                    clk,
    input  logic                    reset_i,

    input  mips_isa_pkg::reg_addr_t raddr1_i,
    input  mips_isa_pkg::reg_addr_t raddr2_i,
    output mips_isa_pkg::word_t     rdata1_o,
    output mips_isa_pkg::word_t     rdata2_o,

    input  logic                    we_i,
    input  mips_isa_pkg::reg_addr_t waddr_i,
    input  mips_isa_pkg::word_t     wdata_i
);

mips_isa_pkg::word_t regs [32];

always_ff @(posedge clk) begin
    if (reset_i) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (we_i) begin
        regs[waddr_i] <= wdata_i;
    end
end

// write-through covers the instruction in writeback
assign rdata1_o = (raddr1_i == '0) ? '0 :
                  (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
assign rdata2_o = (raddr2_i == '0) ? '0 :
                  (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// File: mips_lite.f
logic/mips_isa_pkg.sv
logic/pipe_pkg.sv
logic/inst_fetch.sv
logic/regfile.sv
logic/decode.sv
logic/execute.sv
logic/cpu_core.sv
verif/wb_inst_rom.sv
verif/cpu_core_tb.sv

// File: verif/cpu_core_tb.sv
`timescale 1ns/100ps

module cpu_core_tb;

localparam mips_isa_pkg::word_t RESET_PC = 32'hbfc0_0000;
localparam int DEPTH = 64;
localparam int RAND_LEN = 40;

logic                    clk;
logic                    reset_i;
logic                    wb_cyc, wb_stb, wb_ack;
mips_isa_pkg::word_t     wb_adr, wb_dat;
logic [1:0]              ack_delay;
mips_isa_pkg::word_t     debug_pc, debug_wdata;
logic [3:0]              debug_wen;
mips_isa_pkg::reg_addr_t debug_wnum;

mips_isa_pkg::word_t rng = 32'hf9e6_a312;
mips_isa_pkg::word_t prog [$];
mips_isa_pkg::reg_addr_t prog_dst [$];
mips_isa_pkg::word_t model_rf [32];
mips_isa_pkg::word_t exp_pc [$];
mips_isa_pkg::word_t exp_data [$];
mips_isa_pkg::reg_addr_t exp_num [$];

int error_count = 0;
int tests_run = 0;
int tests_failed = 0;
int writes_seen;
int acks_seen;
int reset_edges;
logic pre_request;
logic pending;
logic have_ack;
mips_isa_pkg::word_t pend_adr, last_ack_adr;

cpu_core #(
    .RESET_PC(RESET_PC)
) cpu_core_i (
    .clk(clk),
    .reset_i(reset_i),
    .wb_cyc_o(wb_cyc),
    .wb_stb_o(wb_stb),
    .wb_adr_o(wb_adr),
    .wb_dat_i(wb_dat),
    .wb_ack_i(wb_ack),
    .debug_wb_pc_o(debug_pc),
    .debug_wb_rf_wen_o(debug_wen),
    .debug_wb_rf_wnum_o(debug_wnum),
    .debug_wb_rf_wdata_o(debug_wdata)
);

wb_inst_rom #(
    .BASE(RESET_PC),
    .DEPTH(DEPTH)
) rom_i (
    .clk(clk),
    .reset_i(reset_i),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_adr_i(wb_adr),
    .wb_dat_o(wb_dat),
    .wb_ack_o(wb_ack),
    .delay_i(ack_delay)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

function automatic mips_isa_pkg::word_t next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
endfunction

// reference model steps one instruction in program order
task automatic model_step(input mips_isa_pkg::word_t inst, input mips_isa_pkg::word_t pc);
    mips_isa_pkg::word_t a, b, sx, zx, val;
    mips_isa_pkg::reg_addr_t dst;
    logic ok;
    a   = model_rf[inst[25:21]];
    b   = model_rf[inst[20:16]];
    sx  = {{16{inst[15]}}, inst[15:0]};
    zx  = {16'h0, inst[15:0]};
    ok  = 1'b1;
    val = '0;
    dst = inst[20:16];
    if (inst[31:26] == mips_isa_pkg::OP_SPECIAL) begin
        dst = inst[15:11];
        case (inst[5:0])
            mips_isa_pkg::FN_SLL:  val = b << inst[10:6];
            mips_isa_pkg::FN_SRL:  val = b >> inst[10:6];
            mips_isa_pkg::FN_SRA:  val = $signed(b) >>> inst[10:6];
            mips_isa_pkg::FN_ADDU: val = a + b;
            mips_isa_pkg::FN_SUBU: val = a - b;
            mips_isa_pkg::FN_AND:  val = a & b;
            mips_isa_pkg::FN_OR:   val = a | b;
            mips_isa_pkg::FN_XOR:  val = a ^ b;
            mips_isa_pkg::FN_NOR:  val = ~(a | b);
            mips_isa_pkg::FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            mips_isa_pkg::FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
            default:               ok = 1'b0;
        endcase
    end else begin
        case (inst[31:26])
            mips_isa_pkg::OP_ADDIU: val = a + sx;
            mips_isa_pkg::OP_SLTI:  val = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            mips_isa_pkg::OP_ANDI:  val = a & zx;
            mips_isa_pkg::OP_ORI:   val = a | zx;
            mips_isa_pkg::OP_XORI:  val = a ^ zx;
            mips_isa_pkg::OP_LUI:   val = {inst[15:0], 16'h0};
            default:                ok = 1'b0;
        endcase
    end
    if (ok && dst != 0) begin
        model_rf[dst] = val;
        exp_pc.push_back(pc);
        exp_num.push_back(dst);
        exp_data.push_back(val);
    end
endtask

function automatic mips_isa_pkg::word_t r_op(int rs, int rt, int rd, int sh,
                                              mips_isa_pkg::funct_t fn);
    return {mips_isa_pkg::OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic mips_isa_pkg::word_t i_op(mips_isa_pkg::opcode_t op, int rs, int rt,
                                              logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

task automatic build_random(input int n);
    mips_isa_pkg::funct_t  fns [11];
    mips_isa_pkg::opcode_t ops [6];
    int kind, rs, rt, rd, d;
    fns = '{mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL, mips_isa_pkg::FN_SRA,
            mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUBU, mips_isa_pkg::FN_AND,
            mips_isa_pkg::FN_OR, mips_isa_pkg::FN_XOR, mips_isa_pkg::FN_NOR,
            mips_isa_pkg::FN_SLT, mips_isa_pkg::FN_SLTU};
    ops = '{mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI, mips_isa_pkg::OP_ANDI,
            mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI};
    for (int i = 0; i < n; i++) begin
        kind = next_rand() % 20;
        rs   = next_rand() % 8;
        rt   = next_rand() % 8;
        rd   = next_rand() % 8;
        d    = next_rand() % 3 + 1;   // distance of a forced dependency
        if (i >= d && next_rand() % 2) begin
            rs = prog_dst[i - d];
            rt = (kind < 3) ? rs : rt;
        end
        if (kind < 11) begin
            prog.push_back(r_op(rs, rt, rd, next_rand() % 32, fns[kind]));
            prog_dst.push_back(rd);
        end else if (kind < 17) begin
            prog.push_back(i_op(ops[kind - 11], rs, rt, 16'(next_rand())));
            prog_dst.push_back(rt);
        end else if (kind == 17) begin
            prog.push_back(i_op(6'h23, rs, rt, 16'(next_rand())));   // lw is unsupported
            prog_dst.push_back(0);
        end else begin
            prog.push_back(r_op(rs, rt, 0, 0, mips_isa_pkg::FN_ADDU));
            prog_dst.push_back(0);
        end
    end
endtask

task automatic build_directed();
    prog.push_back(i_op(mips_isa_pkg::OP_ADDIU, 0, 1, 16'hfffb));  // r1 = -5
    prog.push_back(i_op(mips_isa_pkg::OP_ANDI, 1, 2, 16'h8001));
    prog.push_back(i_op(mips_isa_pkg::OP_LUI, 0, 3, 16'h8765));
    prog.push_back(i_op(mips_isa_pkg::OP_ORI, 3, 3, 16'h4321));
    prog.push_back(i_op(mips_isa_pkg::OP_SLTI, 1, 4, 16'h0000));
    prog.push_back(i_op(mips_isa_pkg::OP_XORI, 3, 5, 16'hffff));
    prog.push_back(i_op(mips_isa_pkg::OP_ADDIU, 1, 0, 16'h0007));  // r0 stays zero
    prog.push_back(32'h0000_0008);                                 // jr is unsupported
    prog.push_back(r_op(0, 1, 6, 0, mips_isa_pkg::FN_ADDU));
    prog.push_back(r_op(0, 1, 7, 4, mips_isa_pkg::FN_SLL));
    prog.push_back(r_op(0, 7, 7, 2, mips_isa_pkg::FN_SRA));
    prog.push_back(r_op(0, 7, 6, 28, mips_isa_pkg::FN_SRL));
    prog.push_back(r_op(0, 1, 4, 0, mips_isa_pkg::FN_SLTU));
    prog.push_back(r_op(3, 0, 5, 0, mips_isa_pkg::FN_NOR));
    prog.push_back(r_op(5, 3, 2, 0, mips_isa_pkg::FN_SUBU));
endtask

// bus and retire checks sample at the rising edge
always @(posedge clk) begin
    if (reset_i) begin
        if (reset_edges > 0) begin
            assert (!wb_cyc && !wb_stb && debug_wen == 0)
            else begin
                $display("[ERROR] %0t bus or write enable active in reset", $time);
                error_count++;
            end
        end
        reset_edges++;
        pre_request = 1'b1;
        pending     = 1'b0;
        have_ack    = 1'b0;
    end else begin
        if (pre_request && !wb_cyc) begin
            assert (!wb_stb && debug_wen == 0)
            else begin
                $display("[ERROR] %0t activity before first request", $time);
                error_count++;
            end
        end else if (pre_request) begin
            pre_request = 1'b0;
            assert (wb_adr == RESET_PC)
            else begin
                $display("[ERROR] %0t first address %h", $time, wb_adr);
                error_count++;
            end
        end
        if (pending) begin
            assert (wb_stb && wb_cyc && wb_adr == pend_adr)
            else begin
                $display("[ERROR] %0t request changed before ack", $time);
                error_count++;
            end
        end
        if (wb_cyc && wb_stb && wb_ack) begin
            assert (!have_ack || wb_adr == last_ack_adr + 4)
            else begin
                $display("[ERROR] %0t ack address %h after %h", $time, wb_adr, last_ack_adr);
                error_count++;
            end
            have_ack     = 1'b1;
            last_ack_adr = wb_adr;
            acks_seen++;
        end
        pending  = wb_cyc && wb_stb && !wb_ack;
        pend_adr = wb_adr;
        if (debug_wen != 0) begin
            writes_seen++;
            if (exp_pc.size() == 0) begin
                $display("[ERROR] %0t unexpected write at pc %h", $time, debug_pc);
                error_count++;
            end else begin
                assert (debug_wen == 4'hf && debug_pc == exp_pc[0] &&
                        debug_wnum == exp_num[0] && debug_wdata == exp_data[0])
                else begin
                    $display("[ERROR] %0t pc %h r%0d=%h, expected pc %h r%0d=%h", $time,
                             debug_pc, debug_wnum, debug_wdata,
                             exp_pc[0], exp_num[0], exp_data[0]);
                    error_count++;
                end
                void'(exp_pc.pop_front());
                void'(exp_num.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end
end

task automatic run_test(input string name, input int n_rand);
    int errs_before, cycles, limit;
    errs_before = error_count;
    prog.delete();
    prog_dst.delete();
    exp_pc.delete();
    exp_num.delete();
    exp_data.delete();
    if (n_rand == 0) begin
        build_directed();
    end else begin
        build_random(n_rand);
    end
    @(negedge clk);
    reset_i     = 1'b1;
    reset_edges = 0;
    for (int i = 0; i < 32; i++) begin
        model_rf[i] = '0;
    end
    for (int i = 0; i < DEPTH; i++) begin
        rom_i.mem[i] = (i < prog.size()) ? prog[i] :
                       32'hfc00_0000 | ((RESET_PC[25:0] + 26'(4 * i)) ^ {20'h0, RESET_PC[31:26]});
    end
    for (int i = 0; i < prog.size(); i++) begin
        model_step(prog[i], RESET_PC + 4 * i);
    end
    repeat (4) @(negedge clk);
    writes_seen = 0;
    acks_seen   = 0;
    reset_i     = 1'b0;
    limit  = prog.size() * 5 + 50;
    cycles = 0;
    while (acks_seen < prog.size() + 4) begin
        @(negedge clk);
        ack_delay = 2'(next_rand() % 4);
        cycles++;
        if (cycles > limit) begin
            $display("timeout: %s did not finish within %0d cycles", name, limit);
            $display("Test failed");
            $finish;
        end
    end
    assert (exp_pc.size() == 0)
    else begin
        $display("[ERROR] %0t %0d expected writes never retired", $time, exp_pc.size());
        error_count++;
    end
    tests_run++;
    if (error_count != errs_before) begin
        tests_failed++;
    end
    $display("%-12s %0d words, %0d writes, %0d errors", name, prog.size(), writes_seen,
             error_count - errs_before);
endtask

initial begin
    reset_i   = 1'b1;
    ack_delay = 2'd0;
    reset_edges = 0;
    run_test("immediates", 0);
    run_test("random_a", RAND_LEN);
    run_test("random_b", RAND_LEN);
    run_test("random_c", RAND_LEN);
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

// File: verif/wb_inst_rom.sv
`timescale 1ns/100ps

module wb_inst_rom #(
    parameter mips_isa_pkg::word_t BASE  = 32'hbfc0_0000,
    parameter int                  DEPTH = 64
) (
    input  logic                clk,
    input  logic                reset_i,

    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  mips_isa_pkg::word_t wb_adr_i,
    output mips_isa_pkg::word_t wb_dat_o,
    output logic                wb_ack_o,

    input  logic [1:0]          delay_i   // wait states for the next access
);

mips_isa_pkg::word_t mem [DEPTH];
mips_isa_pkg::word_t offset;
logic [1:0]          wait_q;
logic [1:0]          delay_q;

assign offset   = wb_adr_i - BASE;
assign wb_ack_o = wb_cyc_i && wb_stb_i && (wait_q == delay_q);

// outside the image every word is an unsupported opcode
always_comb begin
    if (offset < DEPTH * 4) begin
        wb_dat_o = mem[offset >> 2];
    end else begin
        wb_dat_o = 32'hfc00_0000 | (wb_adr_i[25:0] ^ {20'h0, wb_adr_i[31:26]});
    end
end

always_ff @(posedge clk) begin
    if (reset_i || wb_ack_o) begin
        wait_q  <= '0;
        delay_q <= delay_i;
    end else if (wb_cyc_i && wb_stb_i) begin
        wait_q <= wait_q + 2'd1;
    end
end

endmodule
